/* all.f */
aluPkg.sv
aluSlice.sv
operandDecode.sv
resultCollect.sv
aluTop.sv
aluCheck_sva.sv
tbAlu.sv

/* tbAlu.sv */
// Testbench for the ALU with clock, reset, random stimulus, reference model and summary.
`timescale 1ns/1ps

module tbAlu
	import aluPkg::*;
();

	localparam int clockPeriod = 40; // ns.
	localparam int resetCycles = 10;
	localparam int addVectors = 200;
	localparam int subVectors = 200;
	localparam int logicVectors = 200;
	localparam int sltVectors = 200;
	localparam int mixedVectors = 200;
	localparam int totalVectors = addVectors + subVectors + logicVectors + sltVectors
		+ mixedVectors;
	localparam int drainCycles = 2 * 5 + 1; // Pipeline drain per test plus the reset check.
	localparam int timeoutNs = (resetCycles + totalVectors + drainCycles + 10) * clockPeriod;

	logic clk;
	logic rstN;
	aluWord x;
	aluWord y;
	aluOp opcode;
	aluWord f;
	logic overflow;
	logic cout;
	logic zero;

	integer seed;
	int errorCount;
	int testErrors;
	int testVectors;
	int vectorCount;
	int testCount;
	aluWord expFQ[$]; // Expected f, oldest first.
	logic [2:0] expFlagQ[$]; // {overflow, cout, zero}.

	aluTop UUT
	(
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.opcode(opcode),
		.f(f),
		.overflow(overflow),
		.cout(cout),
		.zero(zero)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(clockPeriod / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic modelOp(input aluOp op, input aluWord a, input aluWord b,
		output aluWord ef, output logic eo, output logic ec);
		logic [dataWidth:0] wide;
		wide = {1'b0, a} + {1'b0, b};
		ef = '0;
		eo = 1'b0;
		ec = 1'b0;
		case (op)
			opAdd:
			begin
				ef = wide[dataWidth-1:0];
				ec = wide[dataWidth];
				eo = (a[dataWidth-1] == b[dataWidth-1]) && (ef[dataWidth-1] != a[dataWidth-1]);
			end
			opSub:
			begin
				ef = a - b;
				ec = (a >= b); // No borrow.
				eo = (a[dataWidth-1] != b[dataWidth-1]) && (ef[dataWidth-1] != a[dataWidth-1]);
			end
			opAnd: ef = a & b;
			opOr: ef = a | b;
			opSlt: ef = ($signed(a) < $signed(b)) ? aluWord'(1) : '0;
			default: ef = '0;
		endcase
	endtask

	function automatic aluWord randWord();
		return aluWord'($random(seed));
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Compare tasks
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic checkWord(input aluWord got, input aluWord exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkFront();
		aluWord ef;
		logic [2:0] fl;
		ef = expFQ.pop_front();
		fl = expFlagQ.pop_front();
		checkWord(f, ef, "f");
		checkFlag(overflow, fl[2], "overflow");
		checkFlag(cout, fl[1], "cout");
		checkFlag(zero, fl[0], "zero");
		testVectors++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~

	// Result of a vector is visible two drive slots after it was driven.
	task automatic issueOp(input aluOp op, input aluWord a, input aluWord b);
		aluWord ef;
		logic eo;
		logic ec;
		@(posedge clk);
		#2;
		if (expFQ.size() == 2)
		begin
			checkFront();
		end
		x = a;
		y = b;
		opcode = op;
		modelOp(op, a, b, ef, eo, ec);
		expFQ.push_back(ef);
		expFlagQ.push_back({eo, ec, (ef == '0)});
	endtask

	task automatic drainPipe();
		while (expFQ.size() > 0)
		begin
			@(posedge clk);
			#2;
			checkFront();
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %-8s vectors %0d errors %0d", name, testVectors, testErrors);
		errorCount += testErrors;
		vectorCount += testVectors;
		testErrors = 0;
		testVectors = 0;
		testCount++;
	endtask

	task automatic runAdd();
		aluWord a;
		for (int i = 0; i < addVectors; i++)
		begin
			a = randWord();
			case (i)
				0: issueOp(opAdd, 32'hffff_ffff, 32'h1); // Carry out, zero result.
				1: issueOp(opAdd, 32'h7fff_ffff, 32'h1); // Positive overflow.
				2: issueOp(opAdd, 32'h8000_0000, 32'h8000_0000); // Overflow and carry.
				3: issueOp(opAdd, '0, '0);
				4: issueOp(opAdd, a, -a);
				default: issueOp(opAdd, a, randWord());
			endcase
		end
		drainPipe();
		finishTest("add");
	endtask

	task automatic runSub();
		aluWord a;
		for (int i = 0; i < subVectors; i++)
		begin
			a = randWord();
			case (i)
				0: issueOp(opSub, a, a);
				1: issueOp(opSub, '0, 32'h1); // Borrow.
				2: issueOp(opSub, 32'h8000_0000, 32'h1); // Negative overflow.
				3: issueOp(opSub, 32'h7fff_ffff, 32'hffff_ffff);
				default:
				begin
					if (i % 16 == 5)
					begin
						issueOp(opSub, a, a);
					end
					else
					begin
						issueOp(opSub, a, randWord());
					end
				end
			endcase
		end
		drainPipe();
		finishTest("sub");
	endtask

	task automatic runLogic();
		aluWord r;
		aluOp op;
		for (int i = 0; i < logicVectors; i++)
		begin
			r = randWord();
			op = r[0] ? opAnd : opOr;
			case (i)
				0: issueOp(opAnd, 32'hffff_ffff, '0);
				1: issueOp(opOr, '0, '0);
				2: issueOp(opOr, 32'hffff_ffff, 32'h8000_0000);
				default: issueOp(op, randWord(), randWord());
			endcase
		end
		drainPipe();
		finishTest("and/or");
	endtask

	task automatic runSlt();
		aluWord a;
		for (int i = 0; i < sltVectors; i++)
		begin
			a = randWord();
			case (i)
				0: issueOp(opSlt, 32'hffff_ffff, 32'h1); // -1 < 1.
				1: issueOp(opSlt, 32'h1, 32'hffff_ffff);
				2: issueOp(opSlt, a, a);
				3: issueOp(opSlt, 32'h8000_0000, 32'h7fff_ffff); // Difference overflows.
				4: issueOp(opSlt, 32'h7fff_ffff, 32'h8000_0000);
				default:
				begin
					if (i % 8 == 7)
					begin
						issueOp(opSlt, a, a);
					end
					else
					begin
						issueOp(opSlt, a, randWord());
					end
				end
			endcase
		end
		drainPipe();
		finishTest("slt");
	endtask

	task automatic runMixed();
		aluWord r;
		for (int i = 0; i < mixedVectors; i++)
		begin
			r = randWord();
			issueOp(aluOp'(r[opWidth-1:0]), randWord(), randWord()); // Codes 5 to 7 included.
		end
		drainPipe();
		finishTest("mixed");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		seed = 32'hdda5_c088;
		errorCount = 0;
		testErrors = 0;
		testVectors = 0;
		vectorCount = 0;
		testCount = 0;
		rstN = 1'b0;
		x = '0;
		y = '0;
		opcode = opAdd;
		repeat (resetCycles) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(posedge clk);
		#2;
		checkWord(f, '0, "f after reset");
		checkFlag(overflow, 1'b0, "overflow after reset");
		checkFlag(cout, 1'b0, "cout after reset");
		checkFlag(zero, 1'b0, "zero after reset");
		finishTest("reset");
		runAdd();
		runSub();
		runLogic();
		runSlt();
		runMixed();
		$display("tests %0d, vectors %0d, errors %0d, assertion failures %0d",
			testCount, vectorCount, errorCount, UUT.check.failCount);
		if (errorCount == 0 && UUT.check.failCount == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

	initial
	begin
		#(timeoutNs);
		$display("Simulation timed out before all tests finished");
		$display("Regression failed");
		$finish;
	end

endmodule

/* aluCheck_sva.sv */
// Concurrent assertions on the ALU outputs, a failure count and their bind to the top level.
`timescale 1ns/1ps

module aluCheck
	import aluPkg::*;
(
	input logic clk,
	input logic rstN,
	input aluOp opcode,
	input aluWord f,
	input logic overflow,
	input logic cout,
	input logic zero
);

	int failCount = 0; // Number of failed assertions.

	// The first edge after release still shows reset outputs.
	property zeroMatchesF;
		@(posedge clk) disable iff (!rstN)
		($past(rstN) && $past(rstN, 2)) |-> (zero == (f == '0));
	endproperty

	property logicFlagsLow;
		@(posedge clk) disable iff (!rstN)
		(opcode inside {opAnd, opOr, opSlt}) |-> ##2 (!overflow && !cout);
	endproperty

	property sltIsBit;
		@(posedge clk) disable iff (!rstN)
		(opcode == opSlt) |-> ##2 (f[dataWidth-1:1] == '0);
	endproperty

	assert property (zeroMatchesF)
	else
	begin
		failCount++;
		$error("zero flag disagrees with f");
	end

	assert property (logicFlagsLow)
	else
	begin
		failCount++;
		$error("flags set for a logic or slt result");
	end

	assert property (sltIsBit)
	else
	begin
		failCount++;
		$error("slt result wider than one bit");
	end

endmodule

bind aluTop aluCheck check
(
	.clk(clk),
	.rstN(rstN),
	.opcode(opcode),
	.f(f),
	.overflow(overflow),
	.cout(cout),
	.zero(zero)
);

/* aluTop.sv */
// ALU top level with decode stage, slice chain and collect stage.
`timescale 1ns/1ps

module aluTop
	import aluPkg::*;
(
	input logic clk,
	input logic rstN,
	input aluWord x,
	input aluWord y,
	input aluOp opcode,
	output aluWord f,
	output logic overflow,
	output logic cout,
	output logic zero
);

	aluWord aReg;
	aluWord bReg;
	sliceFunc func;
	logic carryIn;
	aluOp opStage;
	aluWord bitOut;
	logic [dataWidth:0] carry; // carry[k] enters slice k.

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode stage
	// ~~~~~~~~~~~~~~~~~~~~

	operandDecode decode
	(
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.opcode(opcode),
		.aReg(aReg),
		.bReg(bReg),
		.func(func),
		.carryIn(carryIn),
		.opStage(opStage)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Slice chain
	// ~~~~~~~~~~~~~~~~~~~~

	assign carry[0] = carryIn;

	for (genvar k = 0; k < dataWidth; k++)
	begin : gSlice
		aluSlice slice
		(
			.a(aReg[k]),
			.b(bReg[k]),
			.carryIn(carry[k]),
			.func(func),
			.bitOut(bitOut[k]),
			.carryOut(carry[k+1])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Collect stage
	// ~~~~~~~~~~~~~~~~~~~~

	resultCollect collect
	(
		.clk(clk),
		.rstN(rstN),
		.opStage(opStage),
		.bitOut(bitOut),
		.carryMsb(carry[dataWidth-1]), // Into bit 31.
		.carryOut(carry[dataWidth]), // Out of bit 31.
		.f(f),
		.overflow(overflow),
		.cout(cout),
		.zero(zero)
	);

endmodule

/* resultCollect.sv */
// Result assembly, set-less-than, flag logic and output registers.
`timescale 1ns/1ps

module resultCollect
	import aluPkg::*;
(
	input logic clk,
	input logic rstN,
	input aluOp opStage,
	input aluWord bitOut,
	input logic carryMsb,
	input logic carryOut,
	output aluWord f,
	output logic overflow,
	output logic cout,
	output logic zero
);

	logic overflowRaw;
	logic lessBit;
	aluWord nextF;
	logic nextOverflow;
	logic nextCout;
	logic nextZero;
	logic outLive;

	// ~~~~~~~~~~~~~~~~~~~~
	// Adder flags
	// ~~~~~~~~~~~~~~~~~~~~

	// Signed overflow from the carries around the top bit.
	assign overflowRaw = carryMsb ^ carryOut;

	// Sign of x - y, corrected when the difference overflowed.
	assign lessBit = bitOut[dataWidth-1] ^ overflowRaw;

	// ~~~~~~~~~~~~~~~~~~~~
	// Result select
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		nextF = '0;
		nextOverflow = 1'b0;
		nextCout = 1'b0;
		case (opStage)
			opAdd:
			begin
				nextF = bitOut;
				nextOverflow = overflowRaw;
				nextCout = carryOut;
			end
			opSub:
			begin
				nextF = bitOut;
				nextOverflow = overflowRaw;
				nextCout = carryOut; // High when there is no borrow.
			end
			opAnd:
			begin
				nextF = bitOut;
			end
			opOr:
			begin
				nextF = bitOut;
			end
			opSlt:
			begin
				nextF = {{(dataWidth-1){1'b0}}, lessBit};
			end
			default:
			begin
				nextF = '0; // Codes 5 to 7.
			end
		endcase
	end

	assign nextZero = (nextF == '0);

	// ~~~~~~~~~~~~~~~~~~~~
	// Output registers
	// ~~~~~~~~~~~~~~~~~~~~

	// The decode stage still holds its reset values on the first edge
	// after release, so zero is kept low until real data arrives.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outLive <= 1'b0;
		end
		else
		begin
			outLive <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			f <= '0;
			overflow <= 1'b0;
			cout <= 1'b0;
			zero <= 1'b0;
		end
		else
		begin
			f <= nextF;
			overflow <= nextOverflow;
			cout <= nextCout;
			zero <= nextZero & outLive;
		end
	end

endmodule

/* operandDecode.sv */
// Operand registers and opcode decode into slice controls.
`timescale 1ns/1ps

module operandDecode
	import aluPkg::*;
(
	input logic clk,
	input logic rstN,
	input aluWord x,
	input aluWord y,
	input aluOp opcode,
	output aluWord aReg,
	output aluWord bReg,
	output sliceFunc func,
	output logic carryIn,
	output aluOp opStage
);

	sliceFunc nextFunc;
	logic invertB;
	logic nextCarry;
	aluWord bIn;

	// ~~~~~~~~~~~~~~~~~~~~
	// Opcode decode
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		nextFunc = funcNone;
		invertB = 1'b0;
		nextCarry = 1'b0;
		case (opcode)
			opAdd:
			begin
				nextFunc = funcSum;
			end
			opOr:
			begin
				nextFunc = funcOr;
			end
			opAnd:
			begin
				nextFunc = funcAnd;
			end
			opSub:
			begin
				nextFunc = funcSum;
				invertB = 1'b1; // x + ~y + 1.
				nextCarry = 1'b1;
			end
			opSlt:
			begin
				// Same difference as subtract, the sign is picked later.
				nextFunc = funcSum;
				invertB = 1'b1;
				nextCarry = 1'b1;
			end
			default:
			begin
				nextFunc = funcNone; // Codes 5 to 7.
				invertB = 1'b0;
				nextCarry = 1'b0;
			end
		endcase
	end

	assign bIn = invertB ? ~y : y;

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage registers
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			aReg <= '0;
			bReg <= '0;
			func <= funcNone;
			carryIn <= 1'b0;
			opStage <= opAdd;
		end
		else
		begin
			aReg <= x;
			bReg <= bIn;
			func <= nextFunc;
			carryIn <= nextCarry;
			opStage <= opcode; // Travels with the operands to the collect stage.
		end
	end

endmodule

/* aluSlice.sv */
// One-bit ALU slice with full adder, AND and OR.
`timescale 1ns/1ps

module aluSlice
	import aluPkg::*;
(
	input logic a,
	input logic b,
	input logic carryIn,
	input sliceFunc func,
	output logic bitOut,
	output logic carryOut
);

	logic halfSum;
	logic sum;
	logic andBit;
	logic orBit;

	// ~~~~~~~~~~~~~~~~~~~~
	// Full adder
	// ~~~~~~~~~~~~~~~~~~~~

	assign halfSum = a ^ b;
	assign sum = halfSum ^ carryIn;

	// Generate or propagate, independent of func.
	assign carryOut = (a & b) | (halfSum & carryIn);

	// ~~~~~~~~~~~~~~~~~~~~
	// Logic ops
	// ~~~~~~~~~~~~~~~~~~~~

	assign andBit = a & b;
	assign orBit = a | b;

	// ~~~~~~~~~~~~~~~~~~~~
	// Output select
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		case (func)
			funcSum:
			begin
				bitOut = sum;
			end
			funcAnd:
			begin
				bitOut = andBit;
			end
			funcOr:
			begin
				bitOut = orBit;
			end
			default:
			begin
				bitOut = 1'b0; // funcNone.
			end
		endcase
	end

endmodule

/* aluPkg.sv */
// ALU widths, word type, opcode enum and slice function enum.
package aluPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Widths
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int dataWidth = 32; // Operand and result width.
	localparam int opWidth = 3; // Opcode width.
	localparam int funcWidth = 2; // Slice select width.

	// ~~~~~~~~~~~~~~~~~~~~
	// Word type
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [dataWidth-1:0] aluWord;

	// ~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~

	// Codes 5 to 7 have no name and act as no operation.
	typedef enum logic [opWidth-1:0]
	{
		opAdd = 3'd0, // x + y.
		opOr = 3'd1, // Bitwise OR.
		opAnd = 3'd2, // Bitwise AND.
		opSub = 3'd3, // x - y.
		opSlt = 3'd4 // Signed x < y.
	} aluOp;

	// ~~~~~~~~~~~~~~~~~~~~
	// Slice functions
	// ~~~~~~~~~~~~~~~~~~~~

	// What each one-bit slice drives onto its output.
	typedef enum logic [funcWidth-1:0]
	{
		funcSum = 2'd0, // Full adder sum.
		funcAnd = 2'd1, // a AND b.
		funcOr = 2'd2, // a OR b.
		funcNone = 2'd3 // Constant 0.
	} sliceFunc;

endpackage
